//--- source/trellis_settings.svh
// trellis settings: state count, jump rule, datapath widths and trace-back depth

`ifndef TRELLIS_SETTINGS_SVH
`define TRELLIS_SETTINGS_SVH

// trellis shape
`define NUM_STATES   20
`define STATE_JUMP   7    // sel=0 traces +7, sel=1 traces +13 (mod 20)

// datapath widths
`define SAMPLE_WIDTH 8    // signed soft sample
`define METRIC_WIDTH 12   // path metrics wrap, compared modulo 2^12

// trace-back
`define TB_DEPTH     6    // select bits kept per state
`define TRACE_STEPS  3    // steps walked back before the decision

`endif

//--- source/trellisTypesPkg.sv
// trellis data types shared by the path metric, best-state and trace-back blocks

`include "trellis_settings.svh"

package trellisTypesPkg;

   // one soft sample per symbol strobe
   typedef logic signed [`SAMPLE_WIDTH-1:0] softSample_t;

   typedef logic [`METRIC_WIDTH-1:0] pathMetric_t;   // wraps, modular compare only

   typedef logic [$clog2(`NUM_STATES)-1:0] stateIndex_t;

   // one add-compare-select decision per state
   typedef logic [`NUM_STATES-1:0] selVector_t;

endpackage

//--- source/traceCtrlPkg.sv
// trace-back sequencer control type

package traceCtrlPkg;

   // STEP0..STEP2 double as the bit index into a table row
   typedef enum logic [2:0] {
      STEP0 = 3'd0,   // follow bit 0
      STEP1 = 3'd1,   // follow bit 1
      STEP2 = 3'd2,   // follow bit 2, sample predecessor
      LOAD  = 3'd3,   // shift table, take decision, reload pointer
      HOLD  = 3'd4    // idle until next strobe
   } traceStep_t;

endpackage

//--- source/pathMetricUnit.sv
// path metric unit: add-compare-select over all trellis states on each symbol strobe

`include "trellis_settings.svh"

module pathMetricUnit
   import trellisTypesPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        symEn,
   input  softSample_t sample,
   output selVector_t  sel,
   output pathMetric_t metrics [`NUM_STATES]
);

   pathMetric_t sampleExt;              // sample sign-extended to metric width
   pathMetric_t candUp [`NUM_STATES];   // through (s+7) mod 20, plus sample
   pathMetric_t candDn [`NUM_STATES];   // through (s+13) mod 20, minus sample
   pathMetric_t candDiff [`NUM_STATES];
   pathMetric_t metricNext [`NUM_STATES];
   selVector_t  selNext;

   assign sampleExt = pathMetric_t'({{(`METRIC_WIDTH-`SAMPLE_WIDTH){sample[`SAMPLE_WIDTH-1]}},
                                     sample});

   //------------------------------------------------------------
   // branch add and modular compare, one slice per state
   //------------------------------------------------------------
   for (genvar s = 0; s < `NUM_STATES; s++) begin : gAcs
      localparam int PRED_UP = (s + `STATE_JUMP) % `NUM_STATES;
      localparam int PRED_DN = (s + `NUM_STATES - `STATE_JUMP) % `NUM_STATES;

      assign candUp[s] = metrics[PRED_UP] + sampleExt;
      assign candDn[s] = metrics[PRED_DN] - sampleExt;

      // lower path wins only when strictly larger in wrapped arithmetic
      assign candDiff[s] = candDn[s] - candUp[s];
      assign selNext[s]  = (candDiff[s] != '0) && !candDiff[s][`METRIC_WIDTH-1];

      assign metricNext[s] = selNext[s] ? candDn[s] : candUp[s];
   end

   //------------------------------------------------------------
   // metric and select registers
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         sel <= '0;
         for (int s = 0; s < `NUM_STATES; s++) begin
            metrics[s] <= '0;   // all states start equal
         end
      end
      else if (symEn) begin
         sel <= selNext;
         for (int s = 0; s < `NUM_STATES; s++) begin
            metrics[s] <= metricNext[s];
         end
      end
   end

endmodule

//--- source/bestStateFinder.sv
// best-state finder: comparator tree picking the state with the largest path metric

`include "trellis_settings.svh"

module bestStateFinder
   import trellisTypesPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  pathMetric_t metrics [`NUM_STATES],
   output stateIndex_t bestIndex
);

   localparam int LEVELS = $clog2(`NUM_STATES);   // 20 -> 10 -> 5 -> 3 -> 2 -> 1

   pathMetric_t treeMetric [LEVELS+1][`NUM_STATES];
   stateIndex_t treeIndex  [LEVELS+1][`NUM_STATES];

   // level 0 is the raw metric set
   for (genvar s = 0; s < `NUM_STATES; s++) begin : gLeaf
      assign treeMetric[0][s] = metrics[s];
      assign treeIndex[0][s]  = stateIndex_t'(s);
   end

   //------------------------------------------------------------
   // compare levels, left side always holds the lower indices
   //------------------------------------------------------------
   for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : gLevel
      localparam int CNT  = (`NUM_STATES + (1 << lvl) - 1) >> lvl;
      localparam int NEXT = (CNT + 1) / 2;

      for (genvar i = 0; i < NEXT; i++) begin : gNode
         if (2*i + 1 < CNT) begin : gCmp
            pathMetric_t diff;
            logic        takeRight;

            assign diff      = treeMetric[lvl][2*i+1] - treeMetric[lvl][2*i];
            assign takeRight = (diff != '0) && !diff[`METRIC_WIDTH-1];   // ties stay left

            assign treeMetric[lvl+1][i] = takeRight ? treeMetric[lvl][2*i+1]
                                                    : treeMetric[lvl][2*i];
            assign treeIndex[lvl+1][i]  = takeRight ? treeIndex[lvl][2*i+1]
                                                    : treeIndex[lvl][2*i];
         end
         else begin : gPass
            // odd entry out rides up to the next level
            assign treeMetric[lvl+1][i] = treeMetric[lvl][2*i];
            assign treeIndex[lvl+1][i]  = treeIndex[lvl][2*i];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (reset) bestIndex <= '0;
      else       bestIndex <= treeIndex[LEVELS][0];   // registered every cycle
   end

endmodule

//--- source/traceBackTable.sv
// trace-back table: select-bit history per state, 3-step trace-back and decision output

`include "trellis_settings.svh"

module traceBackTable
   import trellisTypesPkg::*;
   import traceCtrlPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        symEn,
   input  selVector_t  sel,
   input  stateIndex_t bestIndex,
   output logic        decision,
   output logic        predecessor
);

   logic [`TB_DEPTH-1:0] tbRow [`NUM_STATES];   // bit 0 holds the newest symbol
   traceStep_t           step;
   logic                 symEnDly;    // sel and bestIndex settle after the strobe
   stateIndex_t          tbPtr;
   logic                 ptrSel;
   logic [$bits(stateIndex_t):0] ptrSum;
   stateIndex_t          ptrNext;

   //------------------------------------------------------------
   // sequencer: HOLD -> STEP0 -> STEP1 -> STEP2 -> LOAD -> HOLD
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         symEnDly <= 1'b0;
         step     <= HOLD;
      end
      else begin
         symEnDly <= symEn;
         case (step)
            HOLD:    if (symEnDly) step <= STEP0;
            STEP0:   step <= STEP1;
            STEP1:   step <= STEP2;
            STEP2:   step <= LOAD;
            default: step <= HOLD;   // LOAD
         endcase
      end
   end

   //------------------------------------------------------------
   // select-bit history
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int s = 0; s < `NUM_STATES; s++) begin
            tbRow[s] <= '0;   // missing history reads as zero
         end
      end
      else if (step == LOAD) begin
         for (int s = 0; s < `NUM_STATES; s++) begin
            tbRow[s] <= {tbRow[s][`TB_DEPTH-2:0], sel[s]};
         end
      end
   end

   // jump rule: sel=0 -> +STATE_JUMP, sel=1 -> -STATE_JUMP, both mod NUM_STATES
   assign ptrSel  = tbRow[tbPtr][step];   // step value is the history bit in STEP0..STEP2
   assign ptrSum  = {1'b0, tbPtr} + (ptrSel ? ($bits(ptrSum))'(`NUM_STATES - `STATE_JUMP)
                                            : ($bits(ptrSum))'(`STATE_JUMP));
   assign ptrNext = (ptrSum >= `NUM_STATES) ? stateIndex_t'(ptrSum - `NUM_STATES)
                                            : stateIndex_t'(ptrSum);

   //------------------------------------------------------------
   // trace pointer
   //------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset)               tbPtr <= '0;
      else if (step == LOAD)   tbPtr <= bestIndex;   // start of next walk
      else if (step != HOLD)   tbPtr <= ptrNext;
   end

   // outputs hold between their update edges
   always_ff @(posedge clk) begin
      if (reset) begin
         decision    <= 1'b0;
         predecessor <= 1'b0;
      end
      else begin
         if (step == STEP2)
            predecessor <= tbRow[bestIndex][0];   // feeds the frequency loop
         if (step == LOAD)
            decision <= tbRow[tbPtr][`TRACE_STEPS];   // read before this edge's shift
      end
   end

endmodule

//--- source/trellisDecoder.sv
// trellis decoder top: path metrics, best-state search and survivor trace-back

`include "trellis_settings.svh"

module trellisDecoder
   import trellisTypesPkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        symEn,
   input  softSample_t sample,
   output logic        decision,
   output logic        predecessor,
   output stateIndex_t bestIndex
);

   selVector_t  sel;                     // valid 1 cycle after symEn
   pathMetric_t metrics [`NUM_STATES];

   pathMetricUnit pathMetrics (
      .clk     (clk),
      .reset   (reset),
      .symEn   (symEn),
      .sample  (sample),
      .sel     (sel),
      .metrics (metrics)
   );

   // bestIndex valid 2 cycles after symEn
   bestStateFinder bestFinder (
      .clk       (clk),
      .reset     (reset),
      .metrics   (metrics),
      .bestIndex (bestIndex)
   );

   traceBackTable traceTable (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .sel         (sel),
      .bestIndex   (bestIndex),
      .decision    (decision),
      .predecessor (predecessor)
   );

endmodule

//--- sim/trellisDecoder_asserts.sv
// trace-back timing checks bound into the trace-back table

module trellisDecoder_asserts
   import traceCtrlPkg::*;
(
   input logic       clk,
   input logic       reset,
   input logic       symEn,
   input traceStep_t step,
   input logic       decision
);

   // strobes at least 5 cycles apart
   symEnSpacing: assert property (@(posedge clk) disable iff (reset)
      symEn |-> !$past(symEn, 1) && !$past(symEn, 2) && !$past(symEn, 3) && !$past(symEn, 4))
      else $error("symEn strobes closer than 5 cycles");

   // exactly one walk per strobe starting two cycles later
   onePass: assert property (@(posedge clk) disable iff (reset)
      (step == STEP0) == $past(symEn, 2))
      else $error("trace walk not started exactly once per strobe");

   decisionStable: assert property (@(posedge clk) disable iff (reset)
      ($past(step) != LOAD) |-> $stable(decision))
      else $error("decision moved outside LOAD");

endmodule

bind traceBackTable trellisDecoder_asserts traceChecks (
   .clk      (clk),
   .reset    (reset),
   .symEn    (symEn),
   .step     (step),
   .decision (decision)
);

//--- sim/trellisDecoder_tb.sv
// trellis decoder testbench: directed tests checked against a reference model of the trellis

`include "trellis_settings.svh"

module trellisDecoder_tb
   import trellisTypesPkg::*;
();

   localparam int HALF_PERIOD    = 20;
   localparam int MIN_GAP        = 5;
   localparam int SLOW_GAP       = 9;
   localparam int RAND_SYMBOLS   = 200;
   localparam int TOTAL_SYMBOLS  = 10 + 12 + 2 * RAND_SYMBOLS;
   localparam int TIMEOUT_CYCLES = TOTAL_SYMBOLS * SLOW_GAP + 200;   // margin for resets, drain

   logic        clk;
   logic        reset;
   logic        symEn;
   softSample_t sample;
   logic        decision;
   logic        predecessor;
   stateIndex_t bestIndex;

   // reference model state
   pathMetric_t modelMetric [`NUM_STATES];
   selVector_t  selHist [TOTAL_SYMBOLS];
   stateIndex_t lastBest;
   int          symCount;

   logic [6:0]  expQ [$];   // {bestIndex, predecessor, decision}
   int          dueQ [$];   // negedge count at which the symbol is checked
   int          tagQ [$];   // slot in obs, -1 when not kept
   logic [6:0]  obs [2*RAND_SYMBOLS];
   softSample_t randSamples [RAND_SYMBOLS];
   logic [31:0] rngState;

   int   cycleCount = 0;
   int   checkCount = 0;
   int   errorCount = 0;
   int   testChecks;
   int   testErrors;
   int   lastStrobe = -100;
   int   prevStrobe = -100;
   logic watchStable = 1'b0;
   logic prevDec;
   logic prevPred;

   trellisDecoder i_dut (
      .clk         (clk),
      .reset       (reset),
      .symEn       (symEn),
      .sample      (sample),
      .decision    (decision),
      .predecessor (predecessor),
      .bestIndex   (bestIndex)
   );

   always #(HALF_PERIOD) clk = ~clk;

   //------------------------------------------------------------
   // reference model
   //------------------------------------------------------------
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   // a beats b when a - b is nonzero with a clear sign bit
   function automatic bit wrapGreater(input pathMetric_t a, input pathMetric_t b);
      pathMetric_t d;
      d = a - b;
      return (d != '0) && !d[`METRIC_WIDTH-1];
   endfunction

   function automatic selVector_t pastSel(input int idx);
      return (idx < 0) ? '0 : selHist[idx];   // no history before the first symbol
   endfunction

   function automatic stateIndex_t traceNext(input stateIndex_t p, input logic bitVal);
      int jump;
      jump = bitVal ? (`NUM_STATES - `STATE_JUMP) : `STATE_JUMP;
      return stateIndex_t'((int'(p) + jump) % `NUM_STATES);
   endfunction

   task automatic modelSymbol(input softSample_t x, output logic expDec,
                              output logic expPred, output stateIndex_t expBest);
      pathMetric_t xe;
      pathMetric_t upC;
      pathMetric_t dnC;
      pathMetric_t nextMetric [`NUM_STATES];
      selVector_t  newSel;
      selVector_t  hs;
      stateIndex_t p;
      xe = pathMetric_t'(int'(x));
      for (int s = 0; s < `NUM_STATES; s++) begin
         upC = modelMetric[(s + `STATE_JUMP) % `NUM_STATES] + xe;
         dnC = modelMetric[(s + `NUM_STATES - `STATE_JUMP) % `NUM_STATES] - xe;
         newSel[s]     = wrapGreater(dnC, upC);
         nextMetric[s] = newSel[s] ? dnC : upC;
      end
      modelMetric = nextMetric;
      expBest = '0;
      for (int s = 1; s < `NUM_STATES; s++) begin
         if (wrapGreater(modelMetric[s], modelMetric[expBest]))
            expBest = stateIndex_t'(s);   // strictly larger only, low index keeps ties
      end
      p = lastBest;
      for (int k = 0; k < `TRACE_STEPS; k++) begin
         hs = pastSel(symCount - 1 - k);
         p  = traceNext(p, hs[p]);
      end
      hs      = pastSel(symCount - 1 - `TRACE_STEPS);
      expDec  = hs[p];
      hs      = pastSel(symCount - 1);
      expPred = hs[expBest];
      selHist[symCount] = newSel;
      lastBest = expBest;
      symCount++;
   endtask

   //------------------------------------------------------------
   // stimulus, checks and report
   //------------------------------------------------------------
   task automatic checkIndex(input string name, input stateIndex_t got, input stateIndex_t exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[ERROR] %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic checkBit(input string name, input logic got, input logic exp);
      checkCount++;
      if (got !== exp) begin
         errorCount++;
         $display("[ERROR] %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic reportFault(input string what);
      errorCount++;
      $display("%0t: %s", $time, what);
   endtask

   task automatic applyReset();
      watchStable = 1'b0;
      @(posedge clk);
      reset <= 1'b1;
      symEn <= 1'b0;
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      foreach (modelMetric[s]) modelMetric[s] = '0;
      symCount    = 0;
      lastBest    = '0;
      lastStrobe  = -100;
      prevStrobe  = -100;
      watchStable = 1'b1;
   endtask

   // one strobe, expected values queued for the check 7 negedges on
   task automatic sendSymbol(input softSample_t x, input int gap, input int tag);
      logic        eDec;
      logic        ePred;
      stateIndex_t eBest;
      modelSymbol(x, eDec, ePred, eBest);
      @(posedge clk);
      symEn <= 1'b1;
      sample <= x;
      prevStrobe = lastStrobe;
      lastStrobe = cycleCount;
      expQ.push_back({eBest, ePred, eDec});
      dueQ.push_back(cycleCount + 7);
      tagQ.push_back(tag);
      @(posedge clk);
      symEn <= 1'b0;
      sample <= '0;
      repeat (gap - 2) @(posedge clk);
   endtask

   always @(negedge clk) begin : outputMonitor
      logic [6:0] expVal;
      cycleCount = cycleCount + 1;
      if (dueQ.size() > 0 && dueQ[0] == cycleCount) begin
         expVal = expQ.pop_front();
         checkIndex("bestIndex", bestIndex, expVal[6:2]);
         checkBit("predecessor", predecessor, expVal[1]);
         checkBit("decision", decision, expVal[0]);
         if (tagQ[0] >= 0)
            obs[tagQ[0]] = {bestIndex, predecessor, decision};
         dueQ.delete(0);
         tagQ.delete(0);
      end
      // decision moves 7 negedges after a strobe, predecessor 6
      if (watchStable && decision !== prevDec &&
          cycleCount != lastStrobe + 7 && cycleCount != prevStrobe + 7)
         reportFault("decision changed between its update edges");
      if (watchStable && predecessor !== prevPred &&
          cycleCount != lastStrobe + 6 && cycleCount != prevStrobe + 6)
         reportFault("predecessor changed between its update edges");
      prevDec  = decision;
      prevPred = predecessor;
   end

   task automatic startTest();
      testChecks = checkCount;
      testErrors = errorCount;
   endtask

   task automatic endTest(input string name);
      while (dueQ.size() > 0) @(posedge clk);
      $display("%-20s %0d checks, %0d errors", name, checkCount - testChecks,
               errorCount - testErrors);
   endtask

   //------------------------------------------------------------
   // directed tests
   //------------------------------------------------------------
   task automatic resetStateTest();
      startTest();
      applyReset();
      @(negedge clk);
      checkIndex("bestIndex", bestIndex, '0);
      checkBit("decision", decision, 1'b0);
      checkBit("predecessor", predecessor, 1'b0);
      endTest("reset state");
   endtask

   // metrics stay equal, trace walks 0, 7, 14, 1
   task automatic zeroSampleTest();
      startTest();
      for (int i = 0; i < 10; i++)
         sendSymbol('0, MIN_GAP, -1);
      endTest("zero samples");
   endtask

   task automatic constantSampleTest();
      startTest();
      for (int i = 0; i < 12; i++)
         sendSymbol(softSample_t'(37), MIN_GAP, -1);
      endTest("constant samples");
   endtask

   task automatic randomRunTest(input int gap, input int tagBase, input string name);
      startTest();
      applyReset();
      for (int i = 0; i < RAND_SYMBOLS; i++)
         sendSymbol(randSamples[i], gap, tagBase + i);
      endTest(name);
   endtask

   // same sequence after reset must give the same outputs at any spacing
   task automatic rerunTest();
      randomRunTest(SLOW_GAP, RAND_SYMBOLS, "random, spacing 9");
      startTest();
      for (int i = 0; i < RAND_SYMBOLS; i++) begin
         checkIndex($sformatf("bestIndex rerun %0d", i), obs[RAND_SYMBOLS+i][6:2], obs[i][6:2]);
         checkBit($sformatf("predecessor rerun %0d", i), obs[RAND_SYMBOLS+i][1], obs[i][1]);
         checkBit($sformatf("decision rerun %0d", i), obs[RAND_SYMBOLS+i][0], obs[i][0]);
      end
      endTest("rerun match");
   endtask

   initial begin
      clk      = 1'b0;
      reset    = 1'b1;
      symEn    = 1'b0;
      sample   = '0;
      rngState = 32'd84;
      for (int i = 0; i < RAND_SYMBOLS; i++) begin
         rngState       = xorshift32(rngState);
         randSamples[i] = softSample_t'(rngState[7:0]);
      end
      resetStateTest();
      zeroSampleTest();
      constantSampleTest();
      randomRunTest(MIN_GAP, 0, "random, spacing 5");
      rerunTest();
      $display("totals: %0d checks, %0d errors", checkCount, errorCount);
      if (errorCount == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

   initial begin : watchdog
      while (cycleCount < TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: no result after %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
   end

endmodule

//--- flist.f
+incdir+source
source/trellisTypesPkg.sv
source/traceCtrlPkg.sv
source/pathMetricUnit.sv
source/bestStateFinder.sv
source/traceBackTable.sv
source/trellisDecoder.sv
sim/trellisDecoder_asserts.sv
sim/trellisDecoder_tb.sv

//--- Makefile
VERILATOR = verilator
TOP       = trellisDecoder_tb
FLIST     = flist.f
FLAGS     = --binary --timing --assert
LINTFLAGS = --lint-only -Wall --timing
OBJDIR    = obj_dir
LOG       = sim.log
FAILMSG   = ** FAIL **
PASSMSG   = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASSMSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
